// File: run_sim.sh
#!/bin/sh
# Build and run the response monitor testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f \
  --top-module response_monitor_tb -o response_monitor_sim
status=0
output=$(./obj_dir/response_monitor_sim 2>&1) || status=$?
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "all tests passed"; then
  exit 0
fi
echo "Simulation failed, exit status $status"
exit 1

// File: sources.f
+incdir+verilog
verilog/resp_pkg.sv
verilog/response_credit_ingress.sv
verilog/command_tag_table.sv
verilog/response_statistics_control.sv
verilog/response_monitor_top.sv
verif/clock_reset_gen.sv
verif/response_monitor_assert.sv
verif/response_monitor_tb.sv

// File: verif/clock_reset_gen.sv
//////////////////////////////
// Testbench clock and reset
// 10 ns clock, rstn low for four cycles
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module clock_reset_gen (
  output logic clock,
  output logic rstn
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Released on a falling edge, clear of the rising edges
  initial begin
    rstn = 1'b0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    rstn = 1'b1;
  end

endmodule

`default_nettype wire

// File: verif/response_monitor_assert.sv
//////////////////////////////
// Ingress stage assertions
// Occupancy, pop and credit rules of the FIFO
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "resp_defs.svh"

module response_monitor_assert (
  input logic                             clock,
  input logic                             rstn,
  input logic [$clog2(`RESP_CREDITS):0]   occupancy,
  input logic                             rsp_valid,
  input logic                             table_busy,
  input logic                             pop_valid,
  input logic                             rsp_credit
);

  // Credits bound the FIFO fill
  occupancy_limit: assert property (@(posedge clock) disable iff (!rstn)
    occupancy <= `RESP_CREDITS)
    else $error("Ingress occupancy above the credit count");

  // Table port belongs to the command, nothing leaves the FIFO
  no_pop_while_busy: assert property (@(posedge clock) disable iff (!rstn)
    table_busy |=> (!rsp_credit && occupancy >= $past(occupancy)))
    else $error("Ingress popped while the tag table was busy");

  // Every popped entry frees one slot and returns one credit
  credit_per_pop: assert property (@(posedge clock) disable iff (!rstn)
    int'(occupancy) == int'($past(occupancy)) + int'($past(rsp_valid)) - int'(rsp_credit))
    else $error("Credit return does not match the FIFO occupancy");

  reset_values: assert property (@(posedge clock)
    !rstn |=> (occupancy == '0 && !rsp_credit && !pop_valid))
    else $error("Ingress not empty and idle during reset");

endmodule

`default_nettype wire

// File: verif/response_monitor_tb.sv
//////////////////////////////
// Response monitor testbench
// Random commands and responses checked against a counter model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "resp_defs.svh"

module response_monitor_tb;

  import resp_pkg::*;

  localparam int NUM_TAGS       = 1 << `RESP_TAG_W;
  localparam int RSP_TOTAL      = 300 + 3 + 120 + 60 + 40;
  // About six cycles per response, bursts included
  localparam int STIM_CYCLES    = RSP_TOTAL * 6;
  localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 200;
  // FIFO empties one entry per cycle once commands stop
  localparam int DRAIN_CYCLES   = `RESP_CREDITS + 4;

  logic                     clock;
  logic                     rstn;
  logic                     enabled_in;
  logic                     cmd_valid;
  logic [`RESP_TAG_W-1:0]   cmd_tag;
  cmd_type_t                cmd_type;
  logic [`RESP_SIZE_W-1:0]  cmd_size;
  logic                     rsp_valid;
  logic [`RESP_TAG_W-1:0]   rsp_tag;
  resp_code_t               rsp_code;
  logic                     rsp_credit;
  logic [`RESP_COUNT_W-1:0] done_count;
  logic [`RESP_COUNT_W-1:0] done_read_count;
  logic [`RESP_COUNT_W-1:0] done_write_count;
  logic [`RESP_COUNT_W-1:0] done_restart_count;
  logic [`RESP_COUNT_W-1:0] read_byte_count;
  logic [`RESP_COUNT_W-1:0] write_byte_count;
  logic [`RESP_COUNT_W-1:0] flushed_count;
  logic [`RESP_COUNT_W-1:0] paged_count;
  logic [`RESP_COUNT_W-1:0] error_count;
  logic [`RESP_COUNT_W-1:0] cycle_count;

  // Expected counters
  logic [`RESP_COUNT_W-1:0] exp_done;
  logic [`RESP_COUNT_W-1:0] exp_done_read;
  logic [`RESP_COUNT_W-1:0] exp_done_write;
  logic [`RESP_COUNT_W-1:0] exp_done_restart;
  logic [`RESP_COUNT_W-1:0] exp_read_bytes;
  logic [`RESP_COUNT_W-1:0] exp_write_bytes;
  logic [`RESP_COUNT_W-1:0] exp_flushed;
  logic [`RESP_COUNT_W-1:0] exp_paged;
  logic [`RESP_COUNT_W-1:0] exp_error;
  logic [`RESP_COUNT_W-1:0] exp_cycles;
  logic [`RESP_COUNT_W-1:0] read_before;
  logic [`RESP_COUNT_W-1:0] write_before;
  logic [`RESP_COUNT_W-1:0] done_before;
  logic [`RESP_COUNT_W-1:0] error_before;
  logic                     en_q;

  // Per-tag sender state is 0 idle, 1 outstanding or 2 in flight
  integer                  seed;
  int                      credits;
  int                      stall_count;
  int                      rsp_sent;
  int                      cycle_total = 0;
  bit                      fail_reported = 1'b0;
  bit                      timed_out = 1'b0;
  bit                      run_passed = 1'b0;
  int                      tag_state [NUM_TAGS];
  cmd_type_t               tag_type  [NUM_TAGS];
  logic [`RESP_SIZE_W-1:0] tag_size  [NUM_TAGS];
  int                      inflight_q [$];

  clock_reset_gen clock_reset_gen_inst (
    .clock (clock),
    .rstn  (rstn)
  );

  response_monitor_top response_monitor_top_inst (
    .clock              (clock),
    .rstn               (rstn),
    .enabled_in         (enabled_in),
    .cmd_valid          (cmd_valid),
    .cmd_tag            (cmd_tag),
    .cmd_type           (cmd_type),
    .cmd_size           (cmd_size),
    .rsp_valid          (rsp_valid),
    .rsp_tag            (rsp_tag),
    .rsp_code           (rsp_code),
    .rsp_credit         (rsp_credit),
    .done_count         (done_count),
    .done_read_count    (done_read_count),
    .done_write_count   (done_write_count),
    .done_restart_count (done_restart_count),
    .read_byte_count    (read_byte_count),
    .write_byte_count   (write_byte_count),
    .flushed_count      (flushed_count),
    .paged_count        (paged_count),
    .error_count        (error_count),
    .cycle_count        (cycle_count)
  );

  bind response_credit_ingress response_monitor_assert response_monitor_assert_inst (
    .clock      (clock),
    .rstn       (rstn),
    .occupancy  (occupancy),
    .rsp_valid  (rsp_valid),
    .table_busy (table_busy),
    .pop_valid  (pop_valid),
    .rsp_credit (rsp_credit)
  );

  // Enable is registered once before it gates the cycle counter
  always @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      en_q       <= 1'b0;
      exp_cycles <= '0;
    end else begin
      en_q <= enabled_in;
      if (en_q) begin
        exp_cycles <= exp_cycles + 1;
      end
    end
  end

  always @(posedge clock) begin
    cycle_total <= cycle_total + 1;
    if (cycle_total >= TIMEOUT_CYCLES) begin
      timed_out = 1'b1;
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $fatal(1, "timeout");
    end
  end

  final begin
    if (!run_passed && !fail_reported && !timed_out) begin
      $display("tests failed");
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got == exp) else begin
      fail_reported = 1'b1;
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic expect_true(input string what, input bit cond);
    assert (cond) else begin
      fail_reported = 1'b1;
      $display("FAILED at %0t: %s", $time, what);
      $display("tests failed");
      $fatal(1, "check failed");
    end
  endtask

  task automatic check_counters(input string where);
    compare_value({where, " done_count"}, done_count, exp_done);
    compare_value({where, " done_read_count"}, done_read_count, exp_done_read);
    compare_value({where, " done_write_count"}, done_write_count, exp_done_write);
    compare_value({where, " done_restart_count"}, done_restart_count, exp_done_restart);
    compare_value({where, " read_byte_count"}, read_byte_count, exp_read_bytes);
    compare_value({where, " write_byte_count"}, write_byte_count, exp_write_bytes);
    compare_value({where, " flushed_count"}, flushed_count, exp_flushed);
    compare_value({where, " paged_count"}, paged_count, exp_paged);
    compare_value({where, " error_count"}, error_count, exp_error);
    compare_value({where, " cycle_count"}, cycle_count, exp_cycles);
  endtask

  //////////////////////////////
  // Stimulus and model
  //////////////////////////////

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  // DONE about half the time
  function automatic resp_code_t pick_code();
    case (rand_below(16))
      0:       return FLUSHED;
      1:       return PAGED;
      2:       return AERROR;
      3:       return DERROR;
      4:       return FAILED;
      5:       return FAULT;
      6:       return NRES;
      7:       return NLOCK;
      default: return DONE;
    endcase
  endfunction

  function automatic cmd_type_t pick_type();
    case (rand_below(3))
      0:       return CMD_READ;
      1:       return CMD_WRITE;
      default: return CMD_RESTART;
    endcase
  endfunction

  // Counted by the enable level at acceptance
  function automatic void account_response(input resp_code_t code, input int t);
    logic [`RESP_COUNT_W-1:0] bytes;
    bytes = '0;
    bytes[`RESP_SIZE_W-1:0] = tag_size[t];
    if (enabled_in) begin
      case (code)
        DONE: begin
          exp_done = exp_done + 1;
          if (tag_type[t] == CMD_READ) begin
            exp_done_read  = exp_done_read + 1;
            exp_read_bytes = exp_read_bytes + bytes;
          end else if (tag_type[t] == CMD_WRITE) begin
            exp_done_write  = exp_done_write + 1;
            exp_write_bytes = exp_write_bytes + bytes;
          end else begin
            exp_done_restart = exp_done_restart + 1;
          end
        end
        FLUSHED: exp_flushed = exp_flushed + 1;
        PAGED:   exp_paged = exp_paged + 1;
        default: exp_error = exp_error + 1;
      endcase
    end
  endfunction

  task automatic collect_credit;
    int t;
    if (rsp_credit) begin
      expect_true("credit returned with no response in flight", inflight_q.size() != 0);
      t = inflight_q.pop_front();
      tag_state[t] = 0;
      credits++;
    end
  endtask

  task automatic send_command(input int t, input cmd_type_t ty,
                              input logic [`RESP_SIZE_W-1:0] sz);
    cmd_valid    = 1'b1;
    cmd_tag      = t[`RESP_TAG_W-1:0];
    cmd_type     = ty;
    cmd_size     = sz;
    tag_type[t]  = ty;
    tag_size[t]  = sz;
    tag_state[t] = 1;
  endtask

  task automatic send_response(input int t, input resp_code_t code);
    rsp_valid    = 1'b1;
    rsp_tag      = t[`RESP_TAG_W-1:0];
    rsp_code     = code;
    credits--;
    tag_state[t] = 2;
    inflight_q.push_back(t);
    rsp_sent++;
    account_response(code, t);
  endtask

  // One falling edge of traffic; a tag in flight is never rewritten
  task automatic drive_cycle(input bit want_cmd, input bit want_rsp);
    int cand [$];
    int t;
    int sz;
    @(negedge clock);
    collect_credit();
    cmd_valid = 1'b0;
    rsp_valid = 1'b0;
    if (want_rsp) begin
      foreach (tag_state[i]) begin
        if (tag_state[i] == 1) begin
          cand.push_back(i);
        end
      end
      if (cand.size() > 0 && credits == 0) begin
        stall_count++;
      end else if (cand.size() > 0) begin
        send_response(cand[rand_below(cand.size())], pick_code());
      end
    end
    if (want_cmd) begin
      t = rand_below(NUM_TAGS);
      while (tag_state[t] == 2) begin
        t = rand_below(NUM_TAGS);
      end
      sz = rand_below(1 << `RESP_SIZE_W);
      send_command(t, pick_type(), sz[`RESP_SIZE_W-1:0]);
    end
  endtask

  task automatic run_traffic(input int num_rsp, input int cmd_pct, input bit bursty);
    int target;
    int burst_left;
    bit want_cmd;
    target     = rsp_sent + num_rsp;
    burst_left = 0;
    while (rsp_sent < target) begin
      if (bursty && burst_left == 0 && rand_below(100) < 8) begin
        burst_left = 8 + rand_below(8);
      end
      want_cmd = (burst_left > 0) || (rand_below(100) < cmd_pct);
      if (burst_left > 0) begin
        burst_left--;
      end
      drive_cycle(want_cmd, rand_below(100) < 70);
    end
  endtask

  // All credits back, then the join and counter stages settle
  task automatic drain_pipeline;
    int waited;
    waited = 0;
    while (credits != `RESP_CREDITS && waited < DRAIN_CYCLES) begin
      drive_cycle(1'b0, 1'b0);
      waited++;
    end
    repeat (3) drive_cycle(1'b0, 1'b0);
  endtask

  task automatic directed_done(input cmd_type_t ty, input logic [`RESP_SIZE_W-1:0] sz);
    int t;
    t = rand_below(NUM_TAGS);
    @(negedge clock);
    collect_credit();
    send_command(t, ty, sz);
    @(negedge clock);
    collect_credit();
    cmd_valid = 1'b0;
    send_response(t, DONE);
    drain_pipeline();
  endtask

  initial begin
    seed        = 32'h9adc;
    enabled_in  = 1'b0;
    cmd_valid   = 1'b0;
    cmd_tag     = '0;
    cmd_type    = CMD_READ;
    cmd_size    = '0;
    rsp_valid   = 1'b0;
    rsp_tag     = '0;
    rsp_code    = DONE;
    credits     = `RESP_CREDITS;
    stall_count = 0;
    rsp_sent    = 0;
    {exp_done, exp_done_read, exp_done_write, exp_done_restart} = '0;
    {exp_read_bytes, exp_write_bytes, exp_flushed, exp_paged, exp_error} = '0;
    foreach (tag_state[i]) begin
      tag_state[i] = 0;
    end

    @(posedge rstn);
    repeat (10) begin
      @(negedge clock);
      expect_true("rsp_credit pulsed with no responses sent", !rsp_credit);
    end
    check_counters("after reset");

    enabled_in = 1'b1;
    run_traffic(300, 40, 1'b0);
    drain_pipeline();
    compare_value("credits after random traffic", credits, `RESP_CREDITS);
    check_counters("random traffic");

    // Restart moves no bytes, read and write add their sizes
    read_before  = exp_read_bytes;
    write_before = exp_write_bytes;
    directed_done(CMD_RESTART, 8'hff);
    compare_value("read bytes after restart", read_byte_count, read_before);
    compare_value("write bytes after restart", write_byte_count, write_before);
    directed_done(CMD_READ, 8'hc3);
    compare_value("read bytes after read", read_byte_count, read_before + 32'hc3);
    directed_done(CMD_WRITE, 8'h5a);
    compare_value("write bytes after write", write_byte_count, write_before + 32'h5a);
    check_counters("byte accounting");

    stall_count = 0;
    run_traffic(120, 30, 1'b1);
    expect_true("sender never ran out of credits during command bursts", stall_count > 0);
    drain_pipeline();
    compare_value("credits after bursts", credits, `RESP_CREDITS);
    check_counters("command bursts");

    done_before  = exp_done;
    error_before = exp_error;
    enabled_in   = 1'b0;
    run_traffic(60, 40, 1'b0);
    drain_pipeline();
    compare_value("done_count while disabled", done_count, done_before);
    compare_value("error_count while disabled", error_count, error_before);
    check_counters("enable low");

    enabled_in = 1'b1;
    run_traffic(40, 40, 1'b0);
    drain_pipeline();
    check_counters("enable restored");

    run_passed = 1'b1;
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/command_tag_table.sv
//////////////////////////////
// Command tag table
// Single-port type and size store, joined to
// popped responses by tag
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "resp_defs.svh"

module command_tag_table (
  input  logic                    clock,
  input  logic                    rstn,
  input  logic                    cmd_valid,
  input  logic [`RESP_TAG_W-1:0]  cmd_tag,
  input  resp_pkg::cmd_type_t     cmd_type,
  input  logic [`RESP_SIZE_W-1:0] cmd_size,
  input  logic                    pop_valid,
  input  logic [`RESP_TAG_W-1:0]  pop_tag,
  input  resp_pkg::resp_code_t    pop_code,
  output logic                    table_busy,
  output logic                    join_valid,
  output resp_pkg::resp_code_t    join_code,
  output resp_pkg::cmd_type_t     join_type,
  output logic [`RESP_SIZE_W-1:0] join_size
);

  import resp_pkg::*;

  localparam int DEPTH = 1 << `RESP_TAG_W;

  cmd_type_t              type_mem [DEPTH];
  logic [`RESP_SIZE_W-1:0] size_mem [DEPTH];

  logic [`RESP_TAG_W-1:0] port_addr;

  // Commands own the port whenever they show up
  assign table_busy = cmd_valid;
  assign port_addr  = cmd_valid ? cmd_tag : pop_tag;

  ///////////////////////////////
  // Table port
  ///////////////////////////////

  always_ff @(posedge clock) begin
    if (cmd_valid) begin
      type_mem[port_addr] <= cmd_type;
      size_mem[port_addr] <= cmd_size;
    end else if (pop_valid) begin
      join_type <= type_mem[port_addr];
      join_size <= size_mem[port_addr];
      join_code <= pop_code;
    end
  end

  // Valid flag for the joined response
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      join_valid <= 1'b0;
    end else begin
      join_valid <= pop_valid && !cmd_valid;
    end
  end

endmodule

`default_nettype wire

// File: verilog/resp_defs.svh
//////////////////////////////
// Response accounting sizes
// Shared widths and the credit count
//////////////////////////////

`ifndef RESP_DEFS_SVH
`define RESP_DEFS_SVH

// Tag width, 32-entry tag table
`define RESP_TAG_W 5

// Transfer size in bytes
`define RESP_SIZE_W 8

// Statistics counters, free running and wrapping
`define RESP_COUNT_W 32

// Response credits, also ingress FIFO depth (power of two, 2 or more)
`define RESP_CREDITS 4

`endif

// File: verilog/resp_pkg.sv
//////////////////////////////
// Response accounting types
// Response codes seen from the memory side and the
// command types recorded in the tag table
//////////////////////////////

`default_nettype none

package resp_pkg;

  // Memory response codes, 8 bits on the wire
  // Encodings not listed here are never counted
  typedef enum logic [7:0] {
    DONE    = 8'h00,
    AERROR  = 8'h01,
    DERROR  = 8'h03,
    NLOCK   = 8'h04,
    NRES    = 8'h05,
    FLUSHED = 8'h06,
    FAULT   = 8'h07,
    FAILED  = 8'h08,
    PAGED   = 8'h0A
  } resp_code_t;

  // Command kinds kept per tag
  typedef enum logic [1:0] {
    CMD_READ    = 2'd0,
    CMD_WRITE   = 2'd1,
    CMD_RESTART = 2'd2
  } cmd_type_t;

endpackage

`default_nettype wire

// File: verilog/response_credit_ingress.sv
//////////////////////////////
// Response ingress buffer
// Credit-sized FIFO, one credit returned per pop,
// pops held off while the tag table is busy
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "resp_defs.svh"

module response_credit_ingress (
  input  logic                   clock,
  input  logic                   rstn,
  input  logic                   rsp_valid,
  input  logic [`RESP_TAG_W-1:0] rsp_tag,
  input  resp_pkg::resp_code_t   rsp_code,
  input  logic                   table_busy,
  output logic                   rsp_credit,
  output logic                   pop_valid,
  output logic [`RESP_TAG_W-1:0] pop_tag,
  output resp_pkg::resp_code_t   pop_code
);

  import resp_pkg::*;

  localparam int PTR_W = $clog2(`RESP_CREDITS);

  // FIFO storage
  logic [`RESP_TAG_W-1:0] tag_mem  [`RESP_CREDITS];
  resp_code_t             code_mem [`RESP_CREDITS];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   occupancy;
  logic             pop;

  ///////////////////////////////
  // Pop side
  ///////////////////////////////

  assign pop       = (occupancy != '0) && !table_busy;
  assign pop_valid = pop;
  assign pop_tag   = tag_mem[rd_ptr];
  assign pop_code  = code_mem[rd_ptr];

  // Sender holds a credit for every free slot, so a push never overflows
  always_ff @(posedge clock) begin
    if (rsp_valid) begin
      tag_mem[wr_ptr]  <= rsp_tag;
      code_mem[wr_ptr] <= rsp_code;
    end
  end

  ///////////////////////////////
  // Pointers and occupancy
  ///////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
    end else begin
      if (rsp_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({rsp_valid, pop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
    end
  end

  // One credit back per popped entry, a cycle later
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rsp_credit <= 1'b0;
    end else begin
      rsp_credit <= pop;
    end
  end

endmodule

`default_nettype wire

// File: verilog/response_monitor_top.sv
//////////////////////////////
// Response monitor top
// Ingress FIFO, tag join and statistics in a chain
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "resp_defs.svh"

module response_monitor_top (
  input  logic                     clock,
  input  logic                     rstn,
  input  logic                     enabled_in,
  input  logic                     cmd_valid,
  input  logic [`RESP_TAG_W-1:0]   cmd_tag,
  input  resp_pkg::cmd_type_t      cmd_type,
  input  logic [`RESP_SIZE_W-1:0]  cmd_size,
  input  logic                     rsp_valid,
  input  logic [`RESP_TAG_W-1:0]   rsp_tag,
  input  resp_pkg::resp_code_t     rsp_code,
  output logic                     rsp_credit,
  output logic [`RESP_COUNT_W-1:0] done_count,
  output logic [`RESP_COUNT_W-1:0] done_read_count,
  output logic [`RESP_COUNT_W-1:0] done_write_count,
  output logic [`RESP_COUNT_W-1:0] done_restart_count,
  output logic [`RESP_COUNT_W-1:0] read_byte_count,
  output logic [`RESP_COUNT_W-1:0] write_byte_count,
  output logic [`RESP_COUNT_W-1:0] flushed_count,
  output logic [`RESP_COUNT_W-1:0] paged_count,
  output logic [`RESP_COUNT_W-1:0] error_count,
  output logic [`RESP_COUNT_W-1:0] cycle_count
);

  import resp_pkg::*;

  // Ingress to table
  logic                   table_busy;
  logic                   pop_valid;
  logic [`RESP_TAG_W-1:0] pop_tag;
  resp_code_t             pop_code;

  // Table to statistics
  logic                    join_valid;
  resp_code_t              join_code;
  cmd_type_t               join_type;
  logic [`RESP_SIZE_W-1:0] join_size;

  response_credit_ingress response_credit_ingress_inst (
    .clock      (clock),
    .rstn       (rstn),
    .rsp_valid  (rsp_valid),
    .rsp_tag    (rsp_tag),
    .rsp_code   (rsp_code),
    .table_busy (table_busy),
    .rsp_credit (rsp_credit),
    .pop_valid  (pop_valid),
    .pop_tag    (pop_tag),
    .pop_code   (pop_code)
  );

  command_tag_table command_tag_table_inst (
    .clock      (clock),
    .rstn       (rstn),
    .cmd_valid  (cmd_valid),
    .cmd_tag    (cmd_tag),
    .cmd_type   (cmd_type),
    .cmd_size   (cmd_size),
    .pop_valid  (pop_valid),
    .pop_tag    (pop_tag),
    .pop_code   (pop_code),
    .table_busy (table_busy),
    .join_valid (join_valid),
    .join_code  (join_code),
    .join_type  (join_type),
    .join_size  (join_size)
  );

  response_statistics_control response_statistics_control_inst (
    .clock              (clock),
    .rstn               (rstn),
    .enabled_in         (enabled_in),
    .join_valid         (join_valid),
    .join_code          (join_code),
    .join_type          (join_type),
    .join_size          (join_size),
    .done_count         (done_count),
    .done_read_count    (done_read_count),
    .done_write_count   (done_write_count),
    .done_restart_count (done_restart_count),
    .read_byte_count    (read_byte_count),
    .write_byte_count   (write_byte_count),
    .flushed_count      (flushed_count),
    .paged_count        (paged_count),
    .error_count        (error_count),
    .cycle_count        (cycle_count)
  );

endmodule

`default_nettype wire

// File: verilog/response_statistics_control.sv
//////////////////////////////
// Response statistics
// Counts joined responses by code and command type,
// plus bytes moved and enabled cycles
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "resp_defs.svh"

module response_statistics_control (
  input  logic                     clock,
  input  logic                     rstn,
  input  logic                     enabled_in,
  input  logic                     join_valid,
  input  resp_pkg::resp_code_t     join_code,
  input  resp_pkg::cmd_type_t      join_type,
  input  logic [`RESP_SIZE_W-1:0]  join_size,
  output logic [`RESP_COUNT_W-1:0] done_count,
  output logic [`RESP_COUNT_W-1:0] done_read_count,
  output logic [`RESP_COUNT_W-1:0] done_write_count,
  output logic [`RESP_COUNT_W-1:0] done_restart_count,
  output logic [`RESP_COUNT_W-1:0] read_byte_count,
  output logic [`RESP_COUNT_W-1:0] write_byte_count,
  output logic [`RESP_COUNT_W-1:0] flushed_count,
  output logic [`RESP_COUNT_W-1:0] paged_count,
  output logic [`RESP_COUNT_W-1:0] error_count,
  output logic [`RESP_COUNT_W-1:0] cycle_count
);

  import resp_pkg::*;

  logic                     enabled;
  logic [`RESP_COUNT_W-1:0] size_ext;

  assign size_ext = {{(`RESP_COUNT_W-`RESP_SIZE_W){1'b0}}, join_size};

  ///////////////////////////////
  // Enable register
  ///////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
    end else begin
      enabled <= enabled_in;
    end
  end

  ///////////////////////////////
  // Counters
  ///////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      done_count         <= '0;
      done_read_count    <= '0;
      done_write_count   <= '0;
      done_restart_count <= '0;
      read_byte_count    <= '0;
      write_byte_count   <= '0;
      flushed_count      <= '0;
      paged_count        <= '0;
      error_count        <= '0;
      cycle_count        <= '0;
    end else if (enabled) begin
      cycle_count <= cycle_count + 1'b1;

      if (join_valid) begin
        case (join_code)
          DONE: begin
            done_count <= done_count + 1'b1;
            // Byte totals only for data-moving commands
            case (join_type)
              CMD_READ: begin
                done_read_count <= done_read_count + 1'b1;
                read_byte_count <= read_byte_count + size_ext;
              end
              CMD_WRITE: begin
                done_write_count <= done_write_count + 1'b1;
                write_byte_count <= write_byte_count + size_ext;
              end
              CMD_RESTART: begin
                done_restart_count <= done_restart_count + 1'b1;
              end
              default: begin
              end
            endcase
          end
          FLUSHED: begin
            flushed_count <= flushed_count + 1'b1;
          end
          PAGED: begin
            paged_count <= paged_count + 1'b1;
          end
          // All error flavours share one counter
          AERROR, DERROR, FAILED, FAULT, NRES, NLOCK: begin
            error_count <= error_count + 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire
